/* all.f */
source/mvm_mem_pkg.sv
source/mvm_calc_pkg.sv
source/job_control.sv
source/input_loader.sv
source/weight_mac.sv
source/result_writer.sv
source/mvm_top.sv
tb/mvm_asserts.sv
tb/tb_mvm.sv

/* Bender.yml */
package:
  name: mvm

sources:
  - source/mvm_mem_pkg.sv
  - source/mvm_calc_pkg.sv
  - source/job_control.sv
  - source/input_loader.sv
  - source/weight_mac.sv
  - source/result_writer.sv
  - source/mvm_top.sv
  - target: test
    files:
      - tb/mvm_asserts.sv
      - tb/tb_mvm.sv

/* tb/tb_mvm.sv */
`timescale 1ns/1ps

module tb_mvm
   import mvm_mem_pkg::*;
   import mvm_calc_pkg::*;
();

   logic    clk;
   logic    rst_n;
   logic    run;
   logic    busy;
   addr_t   in_rd_addr;
   word_t   in_rd_data;
   addr_t   wt_rd_addr;
   word_t   wt_rd_data;
   out_wr_t out_wr;

   word_t  in_mem  [0:4095];
   word_t  wt_mem  [0:4095];
   word_t  out_mem [0:4095];
   int     wr_count [0:MAX_DIM-1];
   int     cur_n;
   int     errors;
   int     tests_run;
   int     tests_failed;
   int     rand_jobs = 10;
   integer seed = 92458;

   mvm_top dut0 (
      .clk        (clk),
      .rst_n      (rst_n),
      .run        (run),
      .busy       (busy),
      .in_rd_addr (in_rd_addr),
      .in_rd_data (in_rd_data),
      .wt_rd_addr (wt_rd_addr),
      .wt_rd_data (wt_rd_data),
      .out_wr     (out_wr)
   );

   always #20 clk = ~clk;

   // synchronous-read memories
   always @(posedge clk) begin
      in_rd_data <= in_mem[in_rd_addr];
      wt_rd_data <= wt_mem[wt_rd_addr];
      if (out_wr.en) out_mem[out_wr.addr] <= out_wr.data;
   end

   function automatic int job_bound(input int n);
      return 4 * (n * n + 2 * n + 20);
   endfunction

   function automatic word_t mask(input int size);
      return word_t'((32'd1 << size) - 32'd1);
   endfunction

   // element of size bits from bit pos of a data area, gathered bit by bit
   function automatic word_t elem_at(input bit wt, input int pos, input int size);
      int b;
      int a;
      word_t e;
      e = '0;
      for (b = 0; b < size; b++) begin
         a = pos + b;
         if (wt) e[b] = wt_mem[WT_DATA_BASE + a / 16][a % 16];
         else e[b] = in_mem[IN_DATA_BASE + a / 16][a % 16];
      end
      return e;
   endfunction

   // expected output word for one row straight from the memory layout
   function automatic word_t ref_mvm(input int row);
      int n;
      int isize;
      int wsize;
      int j;
      word_t x;
      word_t w;
      longint unsigned sum;
      n     = in_mem[IN_HDR_DIM];
      isize = in_mem[IN_HDR_SIZE];
      wsize = wt_mem[WT_HDR_SIZE];
      sum   = 0;
      for (j = 0; j < n; j++) begin
         x   = elem_at(1'b0, j * isize, isize);
         w   = elem_at(1'b1, (row * n + j) * wsize, wsize);
         sum = sum + x * w;
      end
      return word_t'(sum); // mod 2^16
   endfunction

   task automatic fill_mems();
      int a;
      addr_t ad;
      for (a = 0; a < 4096; a++) begin
         ad = addr_t'(a);
         in_mem[a] = {ad[3:0], ad} ^ 16'hc3c3;
         wt_mem[a] = {ad[3:0], ad} ^ 16'h3c3c;
      end
   endtask

   task automatic put_elem(input bit wt, input int pos, input int size, input bit ones);
      int k;
      logic [31:0] pair;
      word_t e;
      e = ones ? mask(size) : (word_t'($random(seed)) & mask(size));
      k = (wt ? WT_DATA_BASE : IN_DATA_BASE) + pos / 16;
      pair = wt ? {wt_mem[k+1], wt_mem[k]} : {in_mem[k+1], in_mem[k]};
      pair = pair | ({16'h0000, e} << (pos % 16));
      if (wt) {wt_mem[k+1], wt_mem[k]} = pair;
      else {in_mem[k+1], in_mem[k]} = pair;
   endtask

   task automatic load_mems(input int n, input int isize, input int wsize, input bit ones);
      int i;
      fill_mems();
      in_mem[IN_HDR_DIM]  = word_t'(n);
      in_mem[IN_HDR_SIZE] = word_t'(isize);
      wt_mem[WT_HDR_SIZE] = word_t'(wsize);
      for (i = 0; i <= (n * isize) / 16; i++) in_mem[IN_DATA_BASE + i] = '0;
      for (i = 0; i <= (n * n * wsize) / 16; i++) wt_mem[WT_DATA_BASE + i] = '0;
      for (i = 0; i < n; i++) put_elem(1'b0, i * isize, isize, ones);
      for (i = 0; i < n * n; i++) put_elem(1'b1, i * wsize, wsize, ones);
   endtask

   task automatic run_job(input string name, input int n, input int isize, input int wsize,
                          input bit ones);
      int cyc;
      int r;
      int errs_before;
      errs_before = errors;
      load_mems(n, isize, wsize, ones);
      cur_n = n;
      for (r = 0; r < MAX_DIM; r++) wr_count[r] = 0;
      @(posedge clk);
      run <= 1'b1;
      cyc = 0;
      while (busy !== 1'b1 && cyc < job_bound(n)) begin
         @(negedge clk);
         cyc++;
      end
      if (busy !== 1'b1) begin
         $display("time %0t: busy did not rise after run", $time);
         errors++;
      end
      @(posedge clk);
      run <= 1'b0;
      cyc = 0;
      while (busy !== 1'b0 && cyc < job_bound(n)) begin
         @(negedge clk);
         cyc++;
      end
      if (busy !== 1'b0) begin
         $display("time %0t: busy did not fall within %0d cycles", $time, job_bound(n));
         errors++;
      end
      repeat (3) @(negedge clk); // stray writes after busy show up here
      for (r = 0; r < n; r++) begin
         if (wr_count[r] != 1) begin
            $display("time %0t: row %0d written %0d times, expected once", $time, r,
                     wr_count[r]);
            errors++;
         end
         if (out_mem[r] !== ref_mvm(r)) begin
            $display("CHECK FAILED t=%0t out_mem[%0d] expected %h got %h", $time, r,
                     ref_mvm(r), out_mem[r]);
            errors++;
         end
      end
      tests_run++;
      if (errors != errs_before) tests_failed++;
      $display("test %-10s n=%0d in=%0d wt=%0d %s", name, n, isize, wsize,
               (errors == errs_before) ? "passed" : "failed");
   endtask

   // checks every output write as it happens
   always @(negedge clk) begin
      if (rst_n && out_wr.en === 1'b1) begin
         if (busy !== 1'b1) begin
            $display("time %0t: output write while busy is low", $time);
            errors++;
         end
         if (out_wr.addr >= cur_n) begin
            $display("time %0t: write to address %0d outside rows 0..%0d", $time,
                     out_wr.addr, cur_n - 1);
            errors++;
         end else begin
            wr_count[out_wr.addr]++;
            if (out_wr.data !== ref_mvm(out_wr.addr)) begin
               $display("CHECK FAILED t=%0t out_wr.data row %0d expected %h got %h", $time,
                        out_wr.addr, ref_mvm(out_wr.addr), out_wr.data);
               errors++;
            end
         end
      end
   end

   initial begin
      longint cycles;
      cycles = 40 + 16 * job_bound(4) + (rand_jobs + 1) * job_bound(16) + 2 * job_bound(5)
               + 8 * (rand_jobs + 19);
      #(cycles * 40);
      $display("timeout: run stopped after %0d cycles", cycles);
      $display("SOME TESTS FAILED");
      $finish;
   end

   initial begin
      int i;
      int j;
      int errs_before;
      clk          = 1'b0;
      rst_n        = 1'b0;
      run          = 1'b0;
      in_rd_data   = '0;
      wt_rd_data   = '0;
      cur_n        = 0;
      errors       = 0;
      tests_run    = 0;
      tests_failed = 0;
      fill_mems();
      repeat (10) @(posedge clk);
      rst_n <= 1'b1;

      errs_before = errors;
      repeat (20) begin
         @(negedge clk);
         if (busy !== 1'b0) begin
            $display("CHECK FAILED t=%0t busy expected 0 got %b", $time, busy);
            errors++;
         end
      end
      tests_run++;
      if (errors != errs_before) tests_failed++;
      $display("test %-10s %s", "idle", (errors == errs_before) ? "passed" : "failed");

      for (i = 0; i < 4; i++) begin
         for (j = 0; j < 4; j++) run_job("sizes", 4, 2 << i, 2 << j, 1'b0);
      end
      for (i = 0; i < rand_jobs; i++) begin
         run_job("random", 1 + $unsigned($random(seed)) % 16, 2 << ($unsigned($random(seed)) % 4),
                 2 << ($unsigned($random(seed)) % 4), 1'b0);
      end
      run_job("wrap", 16, 16, 16, 1'b1);
      run_job("first", 5, 8, 4, 1'b0); // same shape with new data
      run_job("second", 5, 8, 4, 1'b0);

      $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

/* tb/mvm_asserts.sv */
`timescale 1ns/1ps

module mvm_asserts
   import mvm_mem_pkg::*;
(
   input logic    clk,
   input logic    rst_n,
   input logic    run,
   input logic    busy,
   input logic    load_req,
   input logic    load_ack,
   input logic    calc_req,
   input logic    calc_ack,
   input logic    res_req,
   input logic    res_ack,
   input out_wr_t out_wr
);

   // each four-phase req held until its ack
   load_hold: assert property (@(posedge clk) disable iff (!rst_n)
      load_req && !load_ack |=> load_req)
      else $error("load_req dropped before load_ack");

   calc_hold: assert property (@(posedge clk) disable iff (!rst_n)
      calc_req && !calc_ack |=> calc_req)
      else $error("calc_req dropped before calc_ack");

   res_hold: assert property (@(posedge clk) disable iff (!rst_n)
      res_req && !res_ack |=> res_req)
      else $error("res_req dropped before res_ack");

   wr_in_job: assert property (@(posedge clk) disable iff (!rst_n)
      out_wr.en |-> busy)
      else $error("output write outside a job");

   busy_start: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(busy) |-> $past(run))
      else $error("busy rose without run");

endmodule

bind mvm_top mvm_asserts u_asserts (
   .clk      (clk),
   .rst_n    (rst_n),
   .run      (run),
   .busy     (busy),
   .load_req (load_req),
   .load_ack (load_ack),
   .calc_req (calc_req),
   .calc_ack (calc_ack),
   .res_req  (res_req),
   .res_ack  (res_ack),
   .out_wr   (out_wr)
);

/* source/mvm_top.sv */
`timescale 1ns/1ps

module mvm_top
   import mvm_mem_pkg::*;
   import mvm_calc_pkg::*;
(
   input  logic    clk,
   input  logic    rst_n,
   input  logic    run,
   output logic    busy,
   output addr_t   in_rd_addr,
   input  word_t   in_rd_data,
   output addr_t   wt_rd_addr,
   input  word_t   wt_rd_data,
   output out_wr_t out_wr
);

   logic     load_req;
   logic     load_ack;
   logic     calc_req;
   logic     calc_ack;
   logic     res_req;
   logic     res_ack;
   job_cfg_t cfg;
   in_vec_t  in_vec;
   result_t  res;

   job_control u_ctrl (
      .clk      (clk),
      .rst_n    (rst_n),
      .run      (run),
      .busy     (busy),
      .load_req (load_req),
      .load_ack (load_ack),
      .calc_req (calc_req),
      .calc_ack (calc_ack)
   );

   input_loader u_load (
      .clk        (clk),
      .rst_n      (rst_n),
      .load_req   (load_req),
      .load_ack   (load_ack),
      .in_rd_addr (in_rd_addr),
      .in_rd_data (in_rd_data),
      .cfg        (cfg),
      .in_vec     (in_vec)
   );

   weight_mac u_mac (
      .clk        (clk),
      .rst_n      (rst_n),
      .calc_req   (calc_req),
      .calc_ack   (calc_ack),
      .cfg        (cfg),
      .in_vec     (in_vec),
      .wt_rd_addr (wt_rd_addr),
      .wt_rd_data (wt_rd_data),
      .res_req    (res_req),
      .res_ack    (res_ack),
      .res        (res)
   );

   result_writer u_wr (
      .clk     (clk),
      .rst_n   (rst_n),
      .res_req (res_req),
      .res_ack (res_ack),
      .res     (res),
      .out_wr  (out_wr)
   );

endmodule

/* source/result_writer.sv */
`timescale 1ns/1ps

module result_writer
   import mvm_mem_pkg::*;
   import mvm_calc_pkg::*;
(
   input  logic    clk,
   input  logic    rst_n,
   input  logic    res_req,
   output logic    res_ack,
   input  result_t res,
   output out_wr_t out_wr
);

   logic  wr_en;
   addr_t wr_addr;
   word_t wr_data;

   assign out_wr = '{en: wr_en, addr: wr_addr, data: wr_data};

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_en   <= 1'b0;
         res_ack <= 1'b0;
      end else begin
         wr_en <= 1'b0;
         if (res_req && !res_ack) begin // new request only
            wr_en   <= 1'b1;
            res_ack <= 1'b1;
         end else if (!res_req) begin
            res_ack <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      wr_addr <= addr_t'(res.row);
      wr_data <= res.value;
   end

endmodule

/* source/weight_mac.sv */
`timescale 1ns/1ps

module weight_mac
   import mvm_mem_pkg::*;
   import mvm_calc_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,
   input  logic     calc_req,
   output logic     calc_ack,
   input  job_cfg_t cfg,
   input  in_vec_t  in_vec,
   output addr_t    wt_rd_addr,
   input  word_t    wt_rd_data,
   output logic     res_req,
   input  logic     res_ack,
   output result_t  res
);

   typedef enum logic [2:0] {
      W_IDLE,
      W_HDR,
      W_RUN,
      W_DRAIN,
      W_ACK
   } state_t;

   state_t     state;
   esize_t     wsize;
   word_t      cur;       // word being unpacked
   logic       cur_v;
   logic       addr_hold; // wt_rd_data belongs to wt_rd_addr
   logic [3:0] ptr;
   logic [4:0] ptr_nxt;
   dim_t       col_cnt;
   dim_t       row_cnt;
   acc_t       acc;
   acc_t       prod;
   acc_t       sum;
   elem_t      w_elem;
   logic       step;
   logic       row_end;
   logic       last_row;
   logic       load_cur;

   // element stepping halts while a result is outstanding
   assign step     = (state == W_RUN) && cur_v && !res_req && !res_ack;
   assign w_elem   = extract_elem({wt_rd_data, cur}, ptr, wsize);
   assign prod     = acc_t'(w_elem) * acc_t'(in_vec[col_cnt[3:0]]);
   assign sum      = acc + prod;
   assign ptr_nxt  = {1'b0, ptr} + wsize;
   assign row_end  = (col_cnt == cfg.n - 5'd1);
   assign last_row = (row_cnt == cfg.n - 5'd1);
   assign load_cur = (state == W_RUN) && addr_hold && (!cur_v || (step && ptr_nxt[4]));

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state      <= W_IDLE;
         wt_rd_addr <= WT_HDR_SIZE;
         addr_hold  <= 1'b0;
         cur_v      <= 1'b0;
         ptr        <= '0;
         col_cnt    <= '0;
         row_cnt    <= '0;
         res_req    <= 1'b0;
         calc_ack   <= 1'b0;
      end else begin
         addr_hold <= 1'b1;
         if (res_req && res_ack) res_req <= 1'b0;
         if (load_cur) begin // refill overlaps a result wait
            cur_v      <= 1'b1;
            wt_rd_addr <= wt_rd_addr + 12'd1;
            addr_hold  <= 1'b0;
         end else if (step && ptr_nxt[4]) begin
            cur_v <= 1'b0; // next word not back yet
         end
         case (state)
            W_IDLE: if (calc_req) state <= W_HDR;
            W_HDR: begin
               state      <= W_RUN;
               wt_rd_addr <= WT_DATA_BASE;
               addr_hold  <= 1'b0;
               cur_v      <= 1'b0;
               ptr        <= '0;
               col_cnt    <= '0;
               row_cnt    <= '0;
            end
            W_RUN: if (step) begin
               ptr <= ptr_nxt[3:0];
               if (row_end) begin
                  res_req <= 1'b1;
                  col_cnt <= '0;
                  row_cnt <= row_cnt + 5'd1;
                  if (last_row) state <= W_DRAIN;
               end else begin
                  col_cnt <= col_cnt + 5'd1;
               end
            end
            W_DRAIN: if (!res_req && !res_ack) begin
               calc_ack <= 1'b1;
               state    <= W_ACK;
            end
            default: if (!calc_req) begin
               calc_ack   <= 1'b0;
               state      <= W_IDLE;
               wt_rd_addr <= WT_HDR_SIZE;
               addr_hold  <= 1'b0;
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == W_HDR) begin
         wsize <= wt_rd_data[4:0];
         acc   <= '0;
      end
      if (load_cur) cur <= wt_rd_data;
      if (step) begin
         if (row_end) begin
            acc <= '0;
            res <= '{row: row_cnt, value: sum[15:0]}; // low 16 bits only
         end else begin
            acc <= sum;
         end
      end
   end

endmodule

/* source/input_loader.sv */
`timescale 1ns/1ps

module input_loader
   import mvm_mem_pkg::*;
   import mvm_calc_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,
   input  logic     load_req,
   output logic     load_ack,
   output addr_t    in_rd_addr,
   input  word_t    in_rd_data,
   output job_cfg_t cfg,
   output in_vec_t  in_vec
);

   typedef enum logic [2:0] {
      L_IDLE,
      L_DIM,
      L_SIZE,
      L_DATA,
      L_ACK
   } state_t;

   state_t     state;
   dim_t       idx;
   logic [3:0] bit_ptr;
   logic [4:0] ptr_nxt;
   logic       word_ok; // read data matches in_rd_addr

   assign ptr_nxt = {1'b0, bit_ptr} + cfg.in_size;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state      <= L_IDLE;
         in_rd_addr <= IN_HDR_DIM;
         load_ack   <= 1'b0;
         idx        <= '0;
         bit_ptr    <= '0;
         word_ok    <= 1'b0;
      end else begin
         case (state)
            L_IDLE: if (load_req) begin
               state      <= L_DIM;
               in_rd_addr <= IN_HDR_SIZE;
            end
            L_DIM: begin
               state      <= L_SIZE;
               in_rd_addr <= IN_DATA_BASE;
            end
            L_SIZE: begin
               state   <= L_DATA;
               idx     <= '0;
               bit_ptr <= '0;
               word_ok <= 1'b1;
            end
            L_DATA: begin
               if (word_ok) begin
                  idx     <= idx + 5'd1;
                  bit_ptr <= ptr_nxt[3:0];
                  if (ptr_nxt[4]) begin // word used up so fetch the next
                     in_rd_addr <= in_rd_addr + 12'd1;
                     word_ok    <= 1'b0;
                  end
                  if (idx == cfg.n - 5'd1) begin
                     state    <= L_ACK;
                     load_ack <= 1'b1;
                  end
               end else begin
                  word_ok <= 1'b1;
               end
            end
            default: if (!load_req) begin
               load_ack   <= 1'b0;
               state      <= L_IDLE;
               in_rd_addr <= IN_HDR_DIM;
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      case (state)
         L_DIM: cfg.n <= in_rd_data[4:0];
         L_SIZE: begin
            cfg.in_size <= in_rd_data[4:0];
            in_vec      <= '0;
         end
         L_DATA: if (word_ok) begin
            in_vec[idx[3:0]] <= extract_elem({16'h0000, in_rd_data}, bit_ptr, cfg.in_size);
         end
         default: ;
      endcase
   end

endmodule

/* source/job_control.sv */
`timescale 1ns/1ps

module job_control (
   input  logic clk,
   input  logic rst_n,
   input  logic run,
   output logic busy,
   output logic load_req,
   input  logic load_ack,
   output logic calc_req,
   input  logic calc_ack
);

   typedef enum logic [1:0] {
      S_IDLE,
      S_LOAD,
      S_COMPUTE,
      S_DONE
   } state_t;

   state_t state;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state    <= S_IDLE;
         busy     <= 1'b0;
         load_req <= 1'b0;
         calc_req <= 1'b0;
      end else begin
         case (state)
            S_IDLE: if (run) begin
               state    <= S_LOAD;
               busy     <= 1'b1;
               load_req <= 1'b1;
            end
            S_LOAD: begin
               if (load_ack) begin
                  load_req <= 1'b0;
               end else if (!load_req) begin // ack has fallen
                  calc_req <= 1'b1;
                  state    <= S_COMPUTE;
               end
            end
            S_COMPUTE: begin
               if (calc_ack) begin
                  calc_req <= 1'b0;
               end else if (!calc_req) begin
                  busy  <= 1'b0; // all outputs written by now
                  state <= S_DONE;
               end
            end
            default: if (!run) state <= S_IDLE; // wait for host to release run
         endcase
      end
   end

endmodule

/* source/mvm_calc_pkg.sv */
package mvm_calc_pkg;

   import mvm_mem_pkg::*;

   localparam int MAX_DIM = 16;

   typedef logic [4:0]  dim_t;   // 1..16
   typedef logic [4:0]  esize_t; // bits per element
   typedef logic [15:0] elem_t;
   typedef logic [35:0] acc_t;   // 16 products of 16x16

   typedef elem_t [MAX_DIM-1:0] in_vec_t;

   typedef struct packed {
      dim_t   n;
      esize_t in_size;
   } job_cfg_t;

   typedef struct packed {
      dim_t  row;
      word_t value;
   } result_t;

   // pull one element of size bits out of a 32-bit word pair at offs
   function automatic elem_t extract_elem(input logic [31:0] pair, input logic [3:0] offs,
                                          input esize_t size);
      logic [31:0] shifted;
      logic [15:0] mask;
      shifted = pair >> offs;
      mask    = (size >= 5'd16) ? 16'hffff : ((16'd1 << size) - 16'd1);
      return shifted[15:0] & mask;
   endfunction

endpackage

/* source/mvm_mem_pkg.sv */
package mvm_mem_pkg;

   typedef logic [15:0] word_t;
   typedef logic [11:0] addr_t;

   // input memory header
   localparam addr_t IN_HDR_DIM   = 12'd0;
   localparam addr_t IN_HDR_SIZE  = 12'd1;
   localparam addr_t IN_DATA_BASE = 12'd2;

   // weight memory header
   localparam addr_t WT_HDR_SIZE  = 12'd0;
   localparam addr_t WT_DATA_BASE = 12'd1;

   // output memory write port with one word per cycle
   typedef struct packed {
      logic  en;
      addr_t addr;
      word_t data;
   } out_wr_t;

endpackage
